/* include/rtcConsts.svh */
`ifndef RTC_CONSTS_SVH
`define RTC_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// clock field layout
////////////////////////////////////////////////////////////////////////////

`define FIELD_COUNT 9
`define FIELD_BITS 4
`define DATA_BITS 8
`define ADDR_BITS 8

// time and date registers of the RTC chip
`define ADDR_SECONDS 8'h21
`define ADDR_MINUTES 8'h22
`define ADDR_HOURS 8'h23
`define ADDR_DAY 8'h24
`define ADDR_MONTH 8'h25
`define ADDR_YEAR 8'h26

// alarm registers
`define ADDR_ALARM_SECONDS 8'h31
`define ADDR_ALARM_MINUTES 8'h32
`define ADDR_ALARM_HOURS 8'h33

// cycles between starts of two read sweeps
`define REFRESH_PERIOD 2000

`endif

/* logic/rtcPkg.sv */
`include "rtcConsts.svh"

package rtcPkg;

	typedef logic [`FIELD_BITS-1:0] fieldIndex_t;

	// which field group the user is editing
	typedef enum logic [1:0]
	{
		modeOff = 2'd0,
		modeTime = 2'd1,
		modeDate = 2'd2,
		modeAlarm = 2'd3
	} editMode_t;

	// one value per clock field, indexed by field number
	typedef logic [`FIELD_COUNT-1:0][`DATA_BITS-1:0] fieldArray_t;

	// field number to RTC bus address
	function automatic logic [`ADDR_BITS-1:0] fieldAddress(input fieldIndex_t index);
		case (index)
			4'd0: return `ADDR_SECONDS;
			4'd1: return `ADDR_MINUTES;
			4'd2: return `ADDR_HOURS;
			4'd3: return `ADDR_DAY;
			4'd4: return `ADDR_MONTH;
			4'd5: return `ADDR_YEAR;
			4'd6: return `ADDR_ALARM_SECONDS;
			4'd7: return `ADDR_ALARM_MINUTES;
			4'd8: return `ADDR_ALARM_HOURS;
			default: return `ADDR_SECONDS;
		endcase
	endfunction

endpackage

/* logic/rtcReqIf.sv */
`include "rtcConsts.svh"

// one register access on the RTC bus
// req is held with stable fields until done, done lasts one cycle
interface rtcReqIf;

	logic req;
	logic write;
	logic [`ADDR_BITS-1:0] addr;
	logic [`DATA_BITS-1:0] wdata;
	logic [`DATA_BITS-1:0] rdata;
	logic done;

	modport requester
	(
		output req, write, addr, wdata,
		input rdata, done
	);

	modport server
	(
		input req, write, addr, wdata,
		output rdata, done
	);

endinterface

/* logic/fieldEditor.sv */
`include "rtcConsts.svh"

module fieldEditor
	import rtcPkg::*;
(
	input logic CLK,
	input logic reset,
	input editMode_t mode,
	input logic cursorLeft,
	input logic cursorRight,
	input logic valueUp,
	input logic valueDown,
	input logic commit,
	input fieldArray_t shadow,
	output fieldIndex_t cursor,
	output logic [`DATA_BITS-1:0] displayValue,
	output logic editActive,
	output logic commitDone,
	rtcReqIf.requester editReq
);

	localparam fieldIndex_t LastField = fieldIndex_t'(`FIELD_COUNT - 1);

	fieldArray_t ups;
	fieldArray_t downs;
	fieldIndex_t groupFirst;
	fieldIndex_t groupLast;
	fieldIndex_t commitIndex;
	logic inGroup;
	logic committing;
	logic reqOut;
	logic [`ADDR_BITS-1:0] writeAddr;
	logic [`DATA_BITS-1:0] writeData;

	// shadow plus pending user edits, wraps at 256
	function automatic logic [`DATA_BITS-1:0] editedValue(input fieldIndex_t index);
		return shadow[index] + ups[index] - downs[index];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// cursor
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (mode)
			modeTime: begin groupFirst = 4'd0; groupLast = 4'd2; end
			modeDate: begin groupFirst = 4'd3; groupLast = 4'd5; end
			modeAlarm: begin groupFirst = 4'd6; groupLast = 4'd8; end
			default: begin groupFirst = 4'd0; groupLast = LastField; end
		endcase
	end

	assign editActive = (mode != modeOff);
	assign inGroup = (cursor >= groupFirst) && (cursor <= groupLast);
	assign displayValue = editedValue(cursor);

	always_ff @(posedge CLK)
	begin
		if (reset)
			cursor <= '0;
		else if (editActive && !committing)
		begin
			// snap into the group after a mode change
			if (!inGroup)
				cursor <= groupFirst;
			else if (cursorLeft && cursor > groupFirst)
				cursor <= cursor - 1'b1;
			else if (cursorRight && cursor < groupLast)
				cursor <= cursor + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// press counts and commit sequence
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			ups <= '0;
			downs <= '0;
			committing <= 1'b0;
			commitIndex <= '0;
			reqOut <= 1'b0;
			commitDone <= 1'b0;
		end
		else
		begin
			commitDone <= 1'b0;
			if (!committing)
			begin
				if (commit)
				begin
					committing <= 1'b1;
					commitIndex <= '0;
				end
				else if (editActive && inGroup)
				begin
					// up wins when both are pressed
					if (valueUp)
						ups[cursor] <= ups[cursor] + 1'b1;
					else if (valueDown)
						downs[cursor] <= downs[cursor] + 1'b1;
				end
			end
			else if (!reqOut)
				reqOut <= 1'b1;
			else if (editReq.done)
			begin
				reqOut <= 1'b0;
				ups[commitIndex] <= '0;
				downs[commitIndex] <= '0;
				if (commitIndex == LastField)
				begin
					committing <= 1'b0;
					commitDone <= 1'b1;
				end
				else
					commitIndex <= commitIndex + 1'b1;
			end
		end
	end

	// request payload latched as the request goes up
	always_ff @(posedge CLK)
	begin
		if (committing && !reqOut)
		begin
			writeAddr <= fieldAddress(commitIndex);
			writeData <= editedValue(commitIndex);
		end
	end

	assign editReq.req = reqOut;
	assign editReq.write = 1'b1;
	assign editReq.addr = writeAddr;
	assign editReq.wdata = writeData;

endmodule

/* logic/timeRefresher.sv */
`include "rtcConsts.svh"

module timeRefresher
	import rtcPkg::*;
(
	input logic CLK,
	input logic reset,
	output fieldArray_t shadow,
	rtcReqIf.requester refreshReq
);

	localparam int PeriodBits = $clog2(`REFRESH_PERIOD);
	localparam logic [PeriodBits-1:0] PeriodLast = PeriodBits'(`REFRESH_PERIOD - 1);
	localparam fieldIndex_t LastField = fieldIndex_t'(`FIELD_COUNT - 1);

	logic [PeriodBits-1:0] periodCount;
	logic periodExpired;
	logic pending;
	logic sweeping;
	logic reqOut;
	fieldIndex_t readIndex;

	assign periodExpired = (periodCount == PeriodLast);

	// free running period timer
	always_ff @(posedge CLK)
	begin
		if (reset)
			periodCount <= '0;
		else if (periodExpired)
			periodCount <= '0;
		else
			periodCount <= periodCount + 1'b1;
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			// first sweep right after reset
			pending <= 1'b1;
			sweeping <= 1'b0;
			reqOut <= 1'b0;
			readIndex <= '0;
			shadow <= '0;
		end
		else
		begin
			if (periodExpired)
				pending <= 1'b1;
			else if (!sweeping && pending)
				pending <= 1'b0;

			if (!sweeping)
			begin
				if (pending)
				begin
					sweeping <= 1'b1;
					readIndex <= '0;
				end
			end
			else if (!reqOut)
				reqOut <= 1'b1;
			else if (refreshReq.done)
			begin
				reqOut <= 1'b0;
				shadow[readIndex] <= refreshReq.rdata;
				if (readIndex == LastField)
					sweeping <= 1'b0;
				else
					readIndex <= readIndex + 1'b1;
			end
		end
	end

	assign refreshReq.req = reqOut;
	assign refreshReq.write = 1'b0;
	assign refreshReq.addr = fieldAddress(readIndex);
	assign refreshReq.wdata = '0;

endmodule

/* logic/busArbiter.sv */
module busArbiter
(
	input logic CLK,
	input logic reset,
	rtcReqIf.server editReq,
	rtcReqIf.server refreshReq,
	rtcReqIf.requester busReq
);

	logic busy;
	logic ownerEdit;

	////////////////////////////////////////////////////////////////////////////
	// owner register, editor first
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			ownerEdit <= 1'b0;
		end
		else if (!busy)
		begin
			if (editReq.req)
			begin
				busy <= 1'b1;
				ownerEdit <= 1'b1;
			end
			else if (refreshReq.req)
			begin
				busy <= 1'b1;
				ownerEdit <= 1'b0;
			end
		end
		else if (busReq.done)
			busy <= 1'b0;
	end

	// forward the owner's request
	assign busReq.req = busy && (ownerEdit ? editReq.req : refreshReq.req);
	assign busReq.write = ownerEdit ? editReq.write : refreshReq.write;
	assign busReq.addr = ownerEdit ? editReq.addr : refreshReq.addr;
	assign busReq.wdata = ownerEdit ? editReq.wdata : refreshReq.wdata;

	// response only to whoever holds the bus
	assign editReq.done = busy && ownerEdit && busReq.done;
	assign refreshReq.done = busy && !ownerEdit && busReq.done;
	assign editReq.rdata = ownerEdit ? busReq.rdata : '0;
	assign refreshReq.rdata = ownerEdit ? '0 : busReq.rdata;

endmodule

/* logic/rtcBusMaster.sv */
`include "rtcConsts.svh"

module rtcBusMaster
(
	input logic CLK,
	input logic reset,
	input logic [`DATA_BITS-1:0] busRdata,
	input logic busDone,
	output logic [`ADDR_BITS-1:0] busAddr,
	output logic [`DATA_BITS-1:0] busWdata,
	output logic busWrite,
	output logic busRead,
	rtcReqIf.server busReq
);

	typedef enum logic [1:0]
	{
		stIdle,
		stStrobe,
		stFinish
	} masterState_t;

	masterState_t state;
	logic [`DATA_BITS-1:0] readData;

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state <= stIdle;
			busWrite <= 1'b0;
			busRead <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
					if (busReq.req)
					begin
						busWrite <= busReq.write;
						busRead <= !busReq.write;
						state <= stStrobe;
					end
				// hold strobe until the chip answers
				stStrobe:
					if (busDone)
					begin
						busWrite <= 1'b0;
						busRead <= 1'b0;
						state <= stFinish;
					end
				default:
					state <= stIdle;
			endcase
		end
	end

	// address, data and read capture
	always_ff @(posedge CLK)
	begin
		if (state == stIdle && busReq.req)
		begin
			busAddr <= busReq.addr;
			busWdata <= busReq.wdata;
		end
		if (state == stStrobe && busDone)
			readData <= busRdata;
	end

	assign busReq.done = (state == stFinish);
	assign busReq.rdata = readData;

endmodule

/* logic/rtcControl.sv */
`include "rtcConsts.svh"

module rtcControl
	import rtcPkg::*;
(
	input logic CLK,
	input logic reset,
	input editMode_t mode,
	input logic cursorLeft,
	input logic cursorRight,
	input logic valueUp,
	input logic valueDown,
	input logic commit,
	input logic [`DATA_BITS-1:0] busRdata,
	input logic busDone,
	output logic [`ADDR_BITS-1:0] busAddr,
	output logic [`DATA_BITS-1:0] busWdata,
	output logic busWrite,
	output logic busRead,
	output fieldIndex_t cursor,
	output logic [`DATA_BITS-1:0] displayValue,
	output logic editActive,
	output logic commitDone
);

	rtcReqIf editReq();
	rtcReqIf refreshReq();
	rtcReqIf busReq();

	fieldArray_t shadow;

	////////////////////////////////////////////////////////////////////////////
	// two bus masters, one arbiter, one bus driver
	////////////////////////////////////////////////////////////////////////////

	fieldEditor u_fieldEditor
	(
		.CLK(CLK),
		.reset(reset),
		.mode(mode),
		.cursorLeft(cursorLeft),
		.cursorRight(cursorRight),
		.valueUp(valueUp),
		.valueDown(valueDown),
		.commit(commit),
		.shadow(shadow),
		.cursor(cursor),
		.displayValue(displayValue),
		.editActive(editActive),
		.commitDone(commitDone),
		.editReq(editReq.requester)
	);

	timeRefresher u_timeRefresher
	(
		.CLK(CLK),
		.reset(reset),
		.shadow(shadow),
		.refreshReq(refreshReq.requester)
	);

	busArbiter u_busArbiter
	(
		.CLK(CLK),
		.reset(reset),
		.editReq(editReq.server),
		.refreshReq(refreshReq.server),
		.busReq(busReq.requester)
	);

	rtcBusMaster u_rtcBusMaster
	(
		.CLK(CLK),
		.reset(reset),
		.busRdata(busRdata),
		.busDone(busDone),
		.busAddr(busAddr),
		.busWdata(busWdata),
		.busWrite(busWrite),
		.busRead(busRead),
		.busReq(busReq.server)
	);

endmodule

/* dv/rtcModel.sv */
`include "rtcConsts.svh"

// behavioral RTC chip, nine registers on a parallel bus
module rtcModel
(
	input logic CLK,
	input logic reset,
	input logic [`ADDR_BITS-1:0] busAddr,
	input logic [`DATA_BITS-1:0] busWdata,
	input logic busWrite,
	input logic busRead,
	output logic [`DATA_BITS-1:0] busRdata,
	output logic busDone
);

	timeunit 1ns;
	timeprecision 100ps;

	// falling edges after the strobe is seen until busDone
	localparam int AnswerDelay = 2;

	logic [`DATA_BITS-1:0] regs [`FIELD_COUNT];
	int writeCount [`FIELD_COUNT];
	int readCount;
	int badAccesses;
	logic active;
	int delay;

	function automatic int fieldOf(input logic [`ADDR_BITS-1:0] addr);
		case (addr)
			`ADDR_SECONDS: return 0;
			`ADDR_MINUTES: return 1;
			`ADDR_HOURS: return 2;
			`ADDR_DAY: return 3;
			`ADDR_MONTH: return 4;
			`ADDR_YEAR: return 5;
			`ADDR_ALARM_SECONDS: return 6;
			`ADDR_ALARM_MINUTES: return 7;
			`ADDR_ALARM_HOURS: return 8;
			default: return -1;
		endcase
	endfunction

	initial
	begin
		busDone = 1'b0;
		busRdata = '0;
		active = 1'b0;
	end

	// chip side works on the falling edge, the design samples on the rising one
	always @(negedge CLK)
	begin
		int index;
		logic doneBefore;
		index = fieldOf(busAddr);
		doneBefore = busDone;
		busDone = 1'b0;
		if (reset)
		begin
			regs[0] = 8'h10;
			regs[1] = 8'h20;
			regs[2] = 8'h08;
			regs[3] = 8'h15;
			regs[4] = 8'h06;
			regs[5] = 8'h24;
			regs[6] = 8'h05;
			regs[7] = 8'h30;
			regs[8] = 8'h07;
			for (int i = 0; i < `FIELD_COUNT; i++)
				writeCount[i] = 0;
			readCount = 0;
			badAccesses = 0;
			active = 1'b0;
			busRdata = '0;
		end
		else if (active)
		begin
			delay = delay + 1;
			// busDone is sampled three clocks after the strobe rose
			if (delay == AnswerDelay)
			begin
				active = 1'b0;
				busDone = 1'b1;
				if (index < 0)
					badAccesses++;
				else if (busWrite)
				begin
					regs[index] = busWdata;
					writeCount[index]++;
				end
				else
				begin
					busRdata = regs[index];
					readCount++;
				end
			end
		end
		else if ((busWrite || busRead) && !doneBefore)
		begin
			active = 1'b1;
			delay = 0;
		end
	end

endmodule

/* dv/rtcControlTb.sv */
`include "rtcConsts.svh"

module rtcControlTb
	import rtcPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 16;
	localparam int WaitLimit = 5000;
	localparam int BtnLeft = 0;
	localparam int BtnRight = 1;
	localparam int BtnUp = 2;
	localparam int BtnDown = 3;
	localparam int BtnCommit = 4;

	logic CLK;
	logic reset;
	editMode_t mode;
	logic cursorLeft;
	logic cursorRight;
	logic valueUp;
	logic valueDown;
	logic commit;
	logic [`DATA_BITS-1:0] busRdata;
	logic busDone;
	logic [`ADDR_BITS-1:0] busAddr;
	logic [`DATA_BITS-1:0] busWdata;
	logic busWrite;
	logic busRead;
	fieldIndex_t cursor;
	logic [`DATA_BITS-1:0] displayValue;
	logic editActive;
	logic commitDone;

	string testName;
	int testErrors;
	int errors;
	int testsRun;
	int testsFailed;
	logic [7:0] lfsrState;
	// pending edits per field as pressed by the tests
	int delta [`FIELD_COUNT];
	logic [`DATA_BITS-1:0] expected [`FIELD_COUNT];
	int writesBefore [`FIELD_COUNT];

	initial
	begin
		CLK = 1'b0;
		forever #(ClockPeriod / 2) CLK = ~CLK;
	end

	rtcControl u_rtcControl
	(
		.CLK(CLK),
		.reset(reset),
		.mode(mode),
		.cursorLeft(cursorLeft),
		.cursorRight(cursorRight),
		.valueUp(valueUp),
		.valueDown(valueDown),
		.commit(commit),
		.busRdata(busRdata),
		.busDone(busDone),
		.busAddr(busAddr),
		.busWdata(busWdata),
		.busWrite(busWrite),
		.busRead(busRead),
		.cursor(cursor),
		.displayValue(displayValue),
		.editActive(editActive),
		.commitDone(commitDone)
	);

	rtcModel u_rtcModel
	(
		.CLK(CLK),
		.reset(reset),
		.busAddr(busAddr),
		.busWdata(busWdata),
		.busWrite(busWrite),
		.busRead(busRead),
		.busRdata(busRdata),
		.busDone(busDone)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// 8-bit Fibonacci LFSR with taps 8 6 5 4
	function automatic logic [7:0] lfsrNext(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	task automatic drawBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			value = value * 2 + int'(lfsrState[7]);
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic reportMismatch(input string label, input int want, input int got);
		$display("FAILED %s: %s expected 0x%0h, actual 0x%0h", testName, label, want, got);
		testErrors++;
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		testsRun++;
		errors += testErrors;
		if (testErrors == 0)
			$display("%s: passed", testName);
		else
		begin
			testsFailed++;
			$display("%s: %0d errors", testName, testErrors);
		end
	endtask

	task automatic releaseButtons();
		cursorLeft = 1'b0;
		cursorRight = 1'b0;
		valueUp = 1'b0;
		valueDown = 1'b0;
		commit = 1'b0;
	endtask

	// one-cycle pulse that ends on the falling edge after the design took it
	task automatic press(input int button);
		@(negedge CLK);
		case (button)
			BtnLeft: cursorLeft = 1'b1;
			BtnRight: cursorRight = 1'b1;
			BtnUp: valueUp = 1'b1;
			BtnDown: valueDown = 1'b1;
			default: commit = 1'b1;
		endcase
		@(negedge CLK);
		releaseButtons();
	endtask

	task automatic pressTimes(input int button, input int count);
		for (int i = 0; i < count; i++)
			press(button);
	endtask

	task automatic setMode(input editMode_t newMode);
		@(negedge CLK);
		mode = newMode;
		@(negedge CLK);
	endtask

	// cursor must already sit on the field
	task automatic applyCounts(input int field, input int ups, input int downs);
		pressTimes(BtnUp, ups);
		pressTimes(BtnDown, downs);
		delta[field] += ups - downs;
	endtask

	task automatic checkDisplay(input int field);
		int want;
		want = (int'(u_rtcModel.regs[field]) + delta[field]) & 255;
		if (int'(cursor) != field)
			reportMismatch("cursor", field, int'(cursor));
		if (int'(displayValue) != want)
			reportMismatch($sformatf("display of field %0d", field), want,
				int'(displayValue));
	endtask

	// model state only changes on falling edges
	task automatic waitReads(input int target);
		int cycles;
		cycles = 0;
		@(posedge CLK);
		while (u_rtcModel.readCount < target && cycles < WaitLimit)
		begin
			@(posedge CLK);
			cycles++;
		end
		if (u_rtcModel.readCount < target)
		begin
			$display("%s: timed out waiting for %0d bus reads", testName, target);
			testErrors++;
		end
	endtask

	// first read of a sweep in flight while no writes are pending
	task automatic waitSweepStart(output int base);
		int cycles;
		cycles = 0;
		@(posedge CLK);
		while (!(u_rtcModel.active && u_rtcModel.readCount % `FIELD_COUNT == 0)
			&& cycles < WaitLimit)
		begin
			@(posedge CLK);
			cycles++;
		end
		if (!(u_rtcModel.active && u_rtcModel.readCount % `FIELD_COUNT == 0))
		begin
			$display("%s: timed out waiting for a refresh sweep to start", testName);
			testErrors++;
		end
		base = u_rtcModel.readCount;
	endtask

	task automatic waitCommitDone();
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (!commitDone && cycles < WaitLimit)
		begin
			@(negedge CLK);
			cycles++;
		end
		if (!commitDone)
		begin
			$display("%s: timed out waiting for commitDone", testName);
			testErrors++;
		end
	endtask

	task automatic snapshotExpected();
		@(posedge CLK);
		for (int i = 0; i < `FIELD_COUNT; i++)
		begin
			expected[i] = 8'(int'(u_rtcModel.regs[i]) + delta[i]);
			writesBefore[i] = u_rtcModel.writeCount[i];
		end
	endtask

	// every register written once with its pending edits
	task automatic checkWriteBack();
		@(posedge CLK);
		for (int i = 0; i < `FIELD_COUNT; i++)
		begin
			if (u_rtcModel.regs[i] !== expected[i])
				reportMismatch($sformatf("register %0d", i), int'(expected[i]),
					int'(u_rtcModel.regs[i]));
			if (u_rtcModel.writeCount[i] != writesBefore[i] + 1)
				reportMismatch($sformatf("writes to register %0d", i),
					writesBefore[i] + 1, u_rtcModel.writeCount[i]);
			delta[i] = 0;
		end
		if (u_rtcModel.badAccesses != 0)
			reportMismatch("accesses to unknown addresses", 0, u_rtcModel.badAccesses);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic refreshAfterReset();
		startTest("refresh after reset");
		waitReads(`FIELD_COUNT);
		repeat (4) @(posedge CLK);
		setMode(modeTime);
		checkDisplay(0);
		press(BtnRight);
		checkDisplay(1);
		press(BtnRight);
		checkDisplay(2);
		endTest();
	endtask

	task automatic cursorClamping();
		editMode_t modes [4] = '{modeDate, modeAlarm, modeTime, modeDate};
		int firsts [4] = '{3, 6, 0, 3};
		int heldCursor;
		int shown;
		startTest("cursor clamping");
		// each pass ends on the group's last field and the next mode must snap
		for (int m = 0; m < 4; m++)
		begin
			setMode(modes[m]);
			if (int'(cursor) != firsts[m])
				reportMismatch("cursor after mode change", firsts[m], int'(cursor));
			if (editActive !== 1'b1)
				reportMismatch("editActive", 1, int'(editActive));
			pressTimes(BtnRight, 5);
			if (int'(cursor) != firsts[m] + 2)
				reportMismatch("cursor at right end", firsts[m] + 2, int'(cursor));
			pressTimes(BtnLeft, 5);
			if (int'(cursor) != firsts[m])
				reportMismatch("cursor at left end", firsts[m], int'(cursor));
			pressTimes(BtnRight, 5);
		end
		heldCursor = int'(cursor);
		shown = int'(displayValue);
		setMode(modeOff);
		if (editActive !== 1'b0)
			reportMismatch("editActive in modeOff", 0, int'(editActive));
		press(BtnLeft);
		press(BtnUp);
		if (int'(cursor) != heldCursor)
			reportMismatch("cursor after left in modeOff", heldCursor, int'(cursor));
		if (int'(displayValue) != shown)
			reportMismatch("display after up in modeOff", shown, int'(displayValue));
		press(BtnRight);
		press(BtnDown);
		if (int'(cursor) != heldCursor)
			reportMismatch("cursor after right in modeOff", heldCursor, int'(cursor));
		if (int'(displayValue) != shown)
			reportMismatch("display after down in modeOff", shown, int'(displayValue));
		endTest();
	endtask

	task automatic countArithmetic();
		int ups;
		int downs;
		startTest("count arithmetic");
		setMode(modeDate);
		pressTimes(BtnLeft, 2);
		drawBits(5, ups);
		drawBits(3, downs);
		applyCounts(3, ups, downs);
		checkDisplay(3);
		press(BtnRight);
		// month starts at 6 and more downs than that wrap below zero
		drawBits(3, ups);
		drawBits(4, downs);
		downs = downs + ups + 7;
		applyCounts(4, ups, downs);
		checkDisplay(4);
		endTest();
	endtask

	task automatic commitWriteBack();
		int ups;
		startTest("commit write-back");
		setMode(modeAlarm);
		press(BtnRight);
		drawBits(4, ups);
		applyCounts(7, ups + 1, 0);
		checkDisplay(7);
		snapshotExpected();
		press(BtnCommit);
		waitCommitDone();
		checkWriteBack();
		endTest();
	endtask

	task automatic countsCleared();
		int target;
		startTest("counts cleared by commit");
		@(posedge CLK);
		target = u_rtcModel.readCount + `FIELD_COUNT;
		waitReads(target);
		repeat (4) @(posedge CLK);
		checkDisplay(7);
		setMode(modeDate);
		checkDisplay(3);
		press(BtnRight);
		checkDisplay(4);
		endTest();
	endtask

	task automatic commitDuringSweep();
		int ups;
		int downs;
		int sweepBase;
		startTest("commit during a refresh sweep");
		setMode(modeTime);
		drawBits(4, ups);
		applyCounts(0, ups + 1, 0);
		setMode(modeAlarm);
		pressTimes(BtnRight, 2);
		drawBits(4, downs);
		applyCounts(8, 0, downs + 1);
		checkDisplay(8);
		waitSweepStart(sweepBase);
		snapshotExpected();
		press(BtnCommit);
		waitCommitDone();
		checkWriteBack();
		waitReads(sweepBase + `FIELD_COUNT);
		endTest();
	endtask

	initial
	begin
		reset = 1'b1;
		mode = modeOff;
		releaseButtons();
		lfsrState = 8'd25;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		for (int i = 0; i < `FIELD_COUNT; i++)
			delta[i] = 0;
		repeat (ResetCycles) @(negedge CLK);
		reset = 1'b0;

		refreshAfterReset();
		cursorClamping();
		countArithmetic();
		commitWriteBack();
		countsCleared();
		commitDuringSweep();

		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
logic/rtcPkg.sv
logic/rtcReqIf.sv
logic/fieldEditor.sv
logic/timeRefresher.sv
logic/busArbiter.sv
logic/rtcBusMaster.sv
logic/rtcControl.sv
dv/rtcModel.sv
dv/rtcControlTb.sv

/* Makefile */
# Verilator build and run for the RTC front panel testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP ?= rtcControlTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the target fails without the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
